//--- design/ex_pkg.sv
// ----------------------------------------------------------
// Shared definitions for the fixed-latency execute stage
// Data, scoreboard ID and CSR address widths
// Operator encoding and the packed structs passed between
// the issue port, the units and the write-back port
// ----------------------------------------------------------
`default_nettype none

package ex_pkg;

    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned CSR_ADDR_BITS = 12;

    // Operators understood by the fixed-latency units
    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        // Conditional branch compares
        EQ, NE, LTS, GES, LTU, GEU,
        JALR,
        CSR_ACCESS,
        MUL, MULH, MULHU, MULHSU
    } fu_op_e;

    // Issue payload
    typedef struct packed {
        fu_op_e                   operator;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // Prediction from the front end
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] predict_address;
    } branch_predict_t;

    // Branch resolution back to the front end
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target_address;
        logic            is_taken;
        logic            is_mispredict;
    } bp_resolve_t;

    // Write-back into the scoreboard
    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
    } flu_wb_t;

    // One issue bit per unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic csr;
        logic mult;
    } unit_sel_t;

endpackage

`default_nettype wire

//--- design/alu.sv
// ----------------------------------------------------------
// Integer ALU, purely combinational
// Ten arithmetic, logic, shift and compare operations
// Branch comparison outcome for the branch unit
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  ex_pkg::fu_data_t          fu_data_i,
    output logic [ex_pkg::XLEN-1:0]   result_o,
    output logic                      branch_res_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b;
    // Only the low five bits count for a 32 bit shift
    assign shamt = op_b[4:0];

    // Shared comparators for SLT(U) and the branch compares
    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    // ------------------------------------------------------
    // Result
    // ------------------------------------------------------
    always_comb begin
        case (fu_data_i.operator)
            ADD:     result_o = op_a + op_b;
            SUB:     result_o = op_a - op_b;
            AND:     result_o = op_a & op_b;
            OR:      result_o = op_a | op_b;
            XOR:     result_o = op_a ^ op_b;
            SLL:     result_o = op_a << shamt;
            SRL:     result_o = op_a >> shamt;
            SRA:     result_o = $unsigned($signed(op_a) >>> shamt);
            SLT:     result_o = {{(XLEN-1){1'b0}}, lt_s};
            SLTU:    result_o = {{(XLEN-1){1'b0}}, lt_u};
            default: result_o = '0;
        endcase
    end

    // ------------------------------------------------------
    // Branch comparison
    // ------------------------------------------------------
    always_comb begin
        case (fu_data_i.operator)
            EQ:      branch_res_o = (op_a == op_b);
            NE:      branch_res_o = (op_a != op_b);
            LTS:     branch_res_o = lt_s;
            GES:     branch_res_o = ~lt_s;
            LTU:     branch_res_o = lt_u;
            GEU:     branch_res_o = ~lt_u;
            // Jumps are always taken
            JALR:    branch_res_o = 1'b1;
            default: branch_res_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/branch_unit.sv
// ----------------------------------------------------------
// Branch unit, purely combinational
// Jump and branch target, link value (next sequential pc)
// Misprediction check against the front-end prediction
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input  ex_pkg::fu_data_t          fu_data_i,
    input  logic [ex_pkg::XLEN-1:0]   pc_i,
    input  logic                      is_compressed_i,
    input  logic                      branch_valid_i,
    input  logic                      other_valid_i,
    input  logic                      branch_comp_res_i,
    input  ex_pkg::branch_predict_t   branch_predict_i,
    output logic [ex_pkg::XLEN-1:0]   branch_result_o,
    output ex_pkg::bp_resolve_t       resolved_branch_o
);
    import ex_pkg::*;

    logic            is_jalr;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] jump_target;

    assign is_jalr  = (fu_data_i.operator == JALR);
    assign next_pc  = pc_i + (is_compressed_i ? XLEN'(2) : XLEN'(4));
    assign jalr_sum = fu_data_i.operand_a + fu_data_i.imm;

    // JALR is register relative with bit 0 cleared, branches are pc relative
    assign jump_target = is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + fu_data_i.imm;

    // Link value for JALR
    assign branch_result_o = next_pc;

    always_comb begin
        resolved_branch_o       = '0;
        resolved_branch_o.valid = branch_valid_i | other_valid_i;
        resolved_branch_o.pc    = pc_i;

        if (branch_valid_i) begin
            resolved_branch_o.is_taken       = branch_comp_res_i;
            resolved_branch_o.target_address = branch_comp_res_i ? jump_target : next_pc;
            resolved_branch_o.is_mispredict  =
                (branch_comp_res_i != branch_predict_i.taken) ||
                (branch_comp_res_i && (jump_target != branch_predict_i.predict_address));
        end else if (other_valid_i && branch_predict_i.taken) begin
            // Front end jumped on something that is not a branch,
            // so redirect to the instruction that follows it
            resolved_branch_o.target_address = next_pc;
            resolved_branch_o.is_mispredict  = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/csr_buffer.sv
// ----------------------------------------------------------
// Single-entry CSR buffer
// Holds the CSR address until the instruction commits
// Blocks further issue while full
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module csr_buffer (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  ex_pkg::fu_data_t                  fu_data_i,
    input  logic                              csr_valid_i,
    input  logic                              csr_commit_i,
    output logic                              csr_ready_o,
    output logic [ex_pkg::XLEN-1:0]           csr_result_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0]  csr_addr_o
);
    import ex_pkg::*;

    logic                     full_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;

    // Write data goes straight through to the scoreboard
    assign csr_result_o = fu_data_i.operand_a;
    assign csr_ready_o  = ~full_q;
    assign csr_addr_o   = addr_q;

    // Occupancy
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (csr_commit_i || flush_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end
    end

    // Address sits in the low bits of operand b
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= fu_data_i.operand_b[CSR_ADDR_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

//--- design/mult.sv
// ----------------------------------------------------------
// One-cycle pipelined multiplier
// Signed, unsigned and mixed products, low or high half
// Carries the scoreboard ID alongside the result
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mult (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              mult_valid_i,
    input  ex_pkg::fu_data_t  fu_data_i,
    output ex_pkg::flu_wb_t   mult_wb_o
);
    import ex_pkg::*;

    logic                     sign_a;
    logic                     sign_b;
    logic [2*XLEN-1:0]        a_ext;
    logic [2*XLEN-1:0]        b_ext;
    logic [2*XLEN-1:0]        product;
    logic [XLEN-1:0]          result_d;
    logic                     valid_q;
    logic [TRANS_ID_BITS-1:0] trans_id_q;
    logic [XLEN-1:0]          result_q;

    // Operand signedness per operator
    always_comb begin
        case (fu_data_i.operator)
            MULH: begin
                sign_a = 1'b1;
                sign_b = 1'b1;
            end
            MULHSU: begin
                sign_a = 1'b1;
                sign_b = 1'b0;
            end
            default: begin
                sign_a = 1'b0;
                sign_b = 1'b0;
            end
        endcase
    end

    // Extend to 64 bits so a plain modulo product gives the full result
    assign a_ext   = {{XLEN{sign_a & fu_data_i.operand_a[XLEN-1]}}, fu_data_i.operand_a};
    assign b_ext   = {{XLEN{sign_b & fu_data_i.operand_b[XLEN-1]}}, fu_data_i.operand_b};
    assign product = a_ext * b_ext;

    assign result_d = (fu_data_i.operator == MUL) ? product[XLEN-1:0]
                                                  : product[2*XLEN-1:XLEN];

    // ------------------------------------------------------
    // Pipeline register
    // ------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        trans_id_q <= fu_data_i.trans_id;
        result_q   <= result_d;
    end

    // A flush kills the product about to be written back
    assign mult_wb_o.valid    = valid_q & ~flush_i;
    assign mult_wb_o.trans_id = trans_id_q;
    assign mult_wb_o.result   = result_q;

endmodule

`default_nettype wire

//--- design/ex_stage.sv
// ----------------------------------------------------------
// Fixed-latency execute stage
// ALU, branch unit, CSR buffer and multiplier behind one
// issue port, sharing one write-back port to the scoreboard
// Operand silencing, write-back mux and issue ready
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  ex_pkg::fu_data_t                  fu_data_i,
    input  ex_pkg::unit_sel_t                 issue_i,
    input  logic [ex_pkg::XLEN-1:0]           pc_i,
    input  logic                              is_compressed_i,
    input  ex_pkg::branch_predict_t           branch_predict_i,
    input  logic                              csr_commit_i,
    output ex_pkg::flu_wb_t                   flu_wb_o,
    output logic                              flu_ready_o,
    output ex_pkg::bp_resolve_t               resolved_branch_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0]  csr_addr_o
);
    import ex_pkg::*;

    fu_data_t        alu_data;
    fu_data_t        mult_data;
    logic [XLEN-1:0] alu_result;
    logic            alu_branch_res;
    logic [XLEN-1:0] branch_result;
    logic [XLEN-1:0] csr_result;
    logic            csr_ready;
    flu_wb_t         mult_wb;
    logic            other_valid;

    // ------------------------------------------------------
    // Input silencing
    // ------------------------------------------------------
    // ALU also does the compare for the branch unit
    assign alu_data  = (issue_i.alu | issue_i.branch) ? fu_data_i : '0;
    assign mult_data = issue_i.mult ? fu_data_i : '0;

    // Any non-branch issue, checked against a taken prediction
    assign other_valid = issue_i.alu | issue_i.csr | issue_i.mult;

    // ------------------------------------------------------
    // Units
    // ------------------------------------------------------
    alu i_alu (
        .fu_data_i    (alu_data),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    // Unsilenced, the target path is already long
    branch_unit i_branch_unit (
        .fu_data_i         (fu_data_i),
        .pc_i              (pc_i),
        .is_compressed_i   (is_compressed_i),
        .branch_valid_i    (issue_i.branch),
        .other_valid_i     (other_valid),
        .branch_comp_res_i (alu_branch_res),
        .branch_predict_i  (branch_predict_i),
        .branch_result_o   (branch_result),
        .resolved_branch_o (resolved_branch_o)
    );

    csr_buffer i_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fu_data_i    (fu_data_i),
        .csr_valid_i  (issue_i.csr),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    mult i_mult (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .mult_valid_i (issue_i.mult),
        .fu_data_i    (mult_data),
        .mult_wb_o    (mult_wb)
    );

    // ------------------------------------------------------
    // Write-back mux
    // ------------------------------------------------------
    // No arbitration, the issuer keeps sources apart
    always_comb begin
        flu_wb_o.valid    = issue_i.alu | issue_i.branch | issue_i.csr | mult_wb.valid;
        flu_wb_o.trans_id = fu_data_i.trans_id;
        // Link value when nothing else is selected
        flu_wb_o.result   = branch_result;
        if (issue_i.alu) begin
            flu_wb_o.result = alu_result;
        end else if (issue_i.csr) begin
            flu_wb_o.result = csr_result;
        end else if (mult_wb.valid) begin
            flu_wb_o.result   = mult_wb.result;
            flu_wb_o.trans_id = mult_wb.trans_id;
        end
    end

    // Multiplier never stalls, only the CSR buffer does
    assign flu_ready_o = csr_ready;

endmodule

`default_nettype wire

//--- testbench/ex_stage_sva.sv
// ----------------------------------------------------------
// Assertions bound into the execute stage
// Single write-back source, CSR ready protocol,
// no branch resolution without an issue
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ex_stage_sva (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              flush_i,
    input logic              csr_commit_i,
    input ex_pkg::unit_sel_t issue_i,
    input logic              mult_wb_valid_i,
    input logic              flu_ready_i,
    input logic              resolve_valid_i
);
    import ex_pkg::*;

    // ------------------------------------------------------
    // Write-back port
    // ------------------------------------------------------
    a_wb_single_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(mult_wb_valid_i && (issue_i.alu || issue_i.branch || issue_i.csr)))
        else $error("multiplier and a zero-latency unit wrote back together");

    // ------------------------------------------------------
    // CSR buffer
    // ------------------------------------------------------
    a_csr_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (issue_i.csr && !csr_commit_i && !flush_i) |=> !flu_ready_i)
        else $error("ready stayed high after a CSR issue");

    a_csr_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!flu_ready_i && !csr_commit_i && !flush_i) |=> !flu_ready_i)
        else $error("ready rose without commit or flush");

    a_csr_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (csr_commit_i || flush_i) |=> flu_ready_i)
        else $error("ready stayed low after commit or flush");

    // Resolution only for an issued instruction
    a_resolve_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (issue_i == '0) |-> !resolve_valid_i)
        else $error("branch resolution valid with nothing issued");

endmodule

`default_nettype wire

//--- testbench/tb_ex_stage.sv
// ----------------------------------------------------------
// Testbench for the fixed-latency execute stage
// Clock and reset, stimulus table with expected values,
// reference model for ALU, branch, CSR and multiplier,
// typed compare tasks, watchdog and verdict
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 10;
    localparam int DRIVE_DLY  = 5;
    localparam int SAMPLE_DLY = 30;

    localparam unit_sel_t ISSUE_NONE = 4'b0000;
    localparam unit_sel_t ISSUE_ALU  = 4'b1000;
    localparam unit_sel_t ISSUE_BR   = 4'b0100;
    localparam unit_sel_t ISSUE_CSR  = 4'b0010;
    localparam unit_sel_t ISSUE_MUL  = 4'b0001;

    // One table row, stimulus first, then what the DUT must show
    typedef struct packed {
        unit_sel_t                issue;
        fu_data_t                 data;
        logic [XLEN-1:0]          pc;
        logic                     compressed;
        branch_predict_t          pred;
        logic                     commit;
        logic                     flush;
        flu_wb_t                  exp_wb;
        bp_resolve_t              exp_res;
        logic                     chk_target;
        logic                     exp_ready;
        logic [CSR_ADDR_BITS-1:0] exp_addr;
    } row_t;

    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    logic                     flush_i;
    fu_data_t                 fu_data_i;
    unit_sel_t                issue_i;
    logic [XLEN-1:0]          pc_i;
    logic                     is_compressed_i;
    branch_predict_t          branch_predict_i;
    logic                     csr_commit_i;
    flu_wb_t                  flu_wb_o;
    logic                     flu_ready_o;
    bp_resolve_t              resolved_branch_o;
    logic [CSR_ADDR_BITS-1:0] csr_addr_o;

    row_t rows[$];
    int   seed          = 32'ha56c_3df0;
    int   tid_ctr       = 0;
    int   row_idx       = 0;
    logic table_ready   = 1'b0;
    logic passed        = 1'b0;
    logic fail_reported = 1'b0;

    // Reference model state
    flu_wb_t                  pend_wb    = '0;
    logic                     csr_full_m = 1'b0;
    logic [CSR_ADDR_BITS-1:0] csr_addr_m = '0;

    fu_op_e alu_ops [10] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU};
    fu_op_e br_ops  [7]  = '{EQ, NE, LTS, GES, LTU, GEU, JALR};
    fu_op_e mul_ops [4]  = '{MUL, MULH, MULHU, MULHSU};

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ex_stage uut (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .fu_data_i         (fu_data_i),
        .issue_i           (issue_i),
        .pc_i              (pc_i),
        .is_compressed_i   (is_compressed_i),
        .branch_predict_i  (branch_predict_i),
        .csr_commit_i      (csr_commit_i),
        .flu_wb_o          (flu_wb_o),
        .flu_ready_o       (flu_ready_o),
        .resolved_branch_o (resolved_branch_o),
        .csr_addr_o        (csr_addr_o)
    );

    bind ex_stage ex_stage_sva i_sva (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .csr_commit_i    (csr_commit_i),
        .issue_i         (issue_i),
        .mult_wb_valid_i (mult_wb.valid),
        .flu_ready_i     (flu_ready_o),
        .resolve_valid_i (resolved_branch_o.valid)
    );

    // ------------------------------------------------------
    // Reference functions
    // ------------------------------------------------------
    function automatic logic [XLEN-1:0] alu_ref(fu_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $unsigned($signed(a) >>> b[4:0]);
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic logic taken_ref(fu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        case (op)
            EQ:      return a == b;
            NE:      return a != b;
            LTS:     return $signed(a) < $signed(b);
            GES:     return $signed(a) >= $signed(b);
            LTU:     return a < b;
            GEU:     return a >= b;
            JALR:    return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Full 64 bit product in longint, then pick the half
    function automatic logic [XLEN-1:0] mul_ref(fu_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
        longint p;
        case (op)
            MULH:    p = longint'($signed(a)) * longint'($signed(b));
            MULHSU:  p = longint'($signed(a)) * longint'({32'h0, b});
            default: p = longint'({32'h0, a}) * longint'({32'h0, b});
        endcase
        return (op == MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [XLEN-1:0] jump_target(fu_data_t d, logic [XLEN-1:0] pc);
        logic [XLEN-1:0] sum;
        sum = d.operand_a + d.imm;
        if (d.operator == JALR) begin
            return sum & ~32'd1;
        end
        return pc + d.imm;
    endfunction

    function automatic fu_data_t make_data(fu_op_e op, logic [XLEN-1:0] a,
                                           logic [XLEN-1:0] b, logic [XLEN-1:0] imm);
        fu_data_t d;
        d.operator  = op;
        d.operand_a = a;
        d.operand_b = b;
        d.imm       = imm;
        d.trans_id  = TRANS_ID_BITS'(tid_ctr);
        tid_ctr     = tid_ctr + 1;
        return d;
    endfunction

    function automatic branch_predict_t pred_of(logic taken, logic [XLEN-1:0] addr);
        branch_predict_t p;
        p.taken           = taken;
        p.predict_address = addr;
        return p;
    endfunction

    // ------------------------------------------------------
    // Table construction
    // ------------------------------------------------------
    task automatic add_row(input unit_sel_t issue, input fu_data_t d, input logic [XLEN-1:0] pc,
                           input logic comp, input branch_predict_t pred,
                           input logic commit, input logic flush);
        row_t            r;
        logic            tk;
        logic [XLEN-1:0] tgt;
        logic [XLEN-1:0] seq;
        r            = '0;
        r.issue      = issue;
        r.data       = d;
        r.pc         = pc;
        r.compressed = comp;
        r.pred       = pred;
        r.commit     = commit;
        r.flush      = flush;
        seq          = pc + (comp ? 32'd2 : 32'd4);
        tk           = taken_ref(d.operator, d.operand_a, d.operand_b);
        tgt          = jump_target(d, pc);
        r.exp_ready  = !csr_full_m;
        r.exp_addr   = csr_addr_m;

        // Write-back priority ALU, CSR, multiplier, branch link
        r.exp_wb.trans_id = d.trans_id;
        r.exp_wb.valid    = issue.alu | issue.csr | issue.branch;
        if (issue.alu) begin
            r.exp_wb.result = alu_ref(d.operator, d.operand_a, d.operand_b);
        end else if (issue.csr) begin
            r.exp_wb.result = d.operand_a;
        end else if (pend_wb.valid && !flush) begin
            r.exp_wb = pend_wb;
        end else if (issue.branch) begin
            r.exp_wb.result = seq;
        end

        r.exp_res.valid = (issue != ISSUE_NONE);
        r.exp_res.pc    = pc;
        if (issue.branch) begin
            r.exp_res.is_taken       = tk;
            r.exp_res.target_address = tk ? tgt : seq;
            r.exp_res.is_mispredict  = (tk != pred.taken) ||
                                       (tk && (tgt != pred.predict_address));
            r.chk_target             = 1'b1;
        end else if (pred.taken) begin
            r.exp_res.target_address = seq;
            r.exp_res.is_mispredict  = 1'b1;
            r.chk_target             = 1'b1;
        end

        pend_wb = '0;
        if (issue.mult) begin
            pend_wb.valid    = 1'b1;
            pend_wb.trans_id = d.trans_id;
            pend_wb.result   = mul_ref(d.operator, d.operand_a, d.operand_b);
        end
        if (commit || flush) begin
            csr_full_m = 1'b0;
        end else if (issue.csr) begin
            csr_full_m = 1'b1;
            csr_addr_m = d.operand_b[CSR_ADDR_BITS-1:0];
        end
        rows.push_back(r);
    endtask

    task automatic add_idle(input logic commit, input logic flush);
        add_row(ISSUE_NONE, '0, 32'h0000_1000, 1'b0, '0, commit, flush);
    endtask

    task automatic build_table();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] tgt;
        fu_data_t        d;
        int              k;
        add_idle(1'b0, 1'b0);
        for (int p = 0; p < 2; p++) begin
            a = p[0] ? 32'h0000_0005 : 32'h8000_00f3;
            b = p[0] ? 32'hffff_fff0 : 32'h0000_0024;
            for (int i = 0; i < 10; i++) begin
                add_row(ISSUE_ALU, make_data(alu_ops[i], a, b, '0), 32'h0000_0800,
                        1'b0, '0, 1'b0, 1'b0);
            end
        end
        // Branches, predictions cycle through right, wrong target, not taken
        for (int p = 0; p < 2; p++) begin
            a = p[0] ? 32'hffff_fff0 : 32'h0000_0005;
            b = p[0] ? 32'h0000_0003 : 32'h0000_0005;
            for (int i = 0; i < 7; i++) begin
                k   = p * 7 + i;
                pc  = 32'h0000_2000 + 32'(k) * 32'd16;
                d   = make_data(br_ops[i], a, b, p[0] ? 32'hffff_ff80 : 32'h0000_0124);
                tgt = jump_target(d, pc);
                add_row(ISSUE_BR, d, pc, k[2], pred_of(k[0], k[1] ? tgt : tgt + 32'd8),
                        1'b0, 1'b0);
            end
        end
        // Non-branch predicted taken
        add_row(ISSUE_ALU, make_data(ADD, 32'd7, 32'd9, '0), 32'h0000_3000, 1'b0,
                pred_of(1'b1, 32'h0000_3400), 1'b0, 1'b0);
        add_row(ISSUE_ALU, make_data(XOR, 32'h0f0f, 32'h00ff, '0), 32'h0000_3002, 1'b1,
                pred_of(1'b1, 32'h0000_3100), 1'b0, 1'b0);
        // CSR released by commit, then by flush
        add_row(ISSUE_CSR, make_data(CSR_ACCESS, 32'hdead_beef, 32'h0000_0342, '0),
                32'h0000_4000, 1'b0, '0, 1'b0, 1'b0);
        add_idle(1'b0, 1'b0);
        add_idle(1'b1, 1'b0);
        add_idle(1'b0, 1'b0);
        add_row(ISSUE_CSR, make_data(CSR_ACCESS, 32'h1234_5678, 32'h0000_7305, '0),
                32'h0000_4004, 1'b0, '0, 1'b0, 1'b0);
        add_idle(1'b0, 1'b0);
        add_idle(1'b0, 1'b1);
        add_idle(1'b0, 1'b0);
        // Back-to-back multiplies with random operands
        for (int i = 0; i < 12; i++) begin
            a = $random(seed);
            b = $random(seed);
            add_row(ISSUE_MUL, make_data(mul_ops[i % 4], a, b, '0), 32'h0000_5000,
                    1'b0, '0, 1'b0, 1'b0);
        end
        add_idle(1'b0, 1'b0);
        // Multiply killed by a flush in the next cycle
        add_row(ISSUE_MUL, make_data(MULHU, 32'hffff_ffff, 32'hffff_ffff, '0),
                32'h0000_6000, 1'b0, '0, 1'b0, 1'b0);
        add_idle(1'b0, 1'b1);
        add_idle(1'b0, 1'b0);
        add_idle(1'b0, 1'b0);
    endtask

    // ------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------
    task automatic report_failure(input string msg);
        fail_reported = 1'b1;
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_wb(input flu_wb_t got, input flu_wb_t exp);
        if ((got.valid !== exp.valid) || (exp.valid &&
            ((got.trans_id !== exp.trans_id) || (got.result !== exp.result)))) begin
            report_failure($sformatf(
                "error: t=%0t row %0d write-back v=%b id=%0d res=%h, expected v=%b id=%0d res=%h",
                $time, row_idx, got.valid, got.trans_id, got.result,
                exp.valid, exp.trans_id, exp.result));
        end
    endtask

    task automatic check_resolve(input bp_resolve_t got, input bp_resolve_t exp,
                                 input logic chk_target);
        logic bad;
        bad = (got.valid !== exp.valid);
        if (exp.valid) begin
            bad = bad || (got.pc !== exp.pc) || (got.is_taken !== exp.is_taken) ||
                  (got.is_mispredict !== exp.is_mispredict) ||
                  (chk_target && (got.target_address !== exp.target_address));
        end
        if (bad) begin
            report_failure($sformatf(
                "error: t=%0t row %0d resolve v=%b tk=%b mp=%b tgt=%h, expected v=%b tk=%b mp=%b tgt=%h",
                $time, row_idx, got.valid, got.is_taken, got.is_mispredict, got.target_address,
                exp.valid, exp.is_taken, exp.is_mispredict, exp.target_address));
        end
    endtask

    task automatic check_csr(input logic got_ready, input logic [CSR_ADDR_BITS-1:0] got_addr,
                             input logic exp_ready, input logic [CSR_ADDR_BITS-1:0] exp_addr);
        // Address only means something while the buffer is full
        if ((got_ready !== exp_ready) || (!exp_ready && (got_addr !== exp_addr))) begin
            report_failure($sformatf(
                "error: t=%0t row %0d ready=%b addr=%h, expected ready=%b addr=%h",
                $time, row_idx, got_ready, got_addr, exp_ready, exp_addr));
        end
    endtask

    task automatic apply_row(input row_t r);
        issue_i          = r.issue;
        fu_data_i        = r.data;
        pc_i             = r.pc;
        is_compressed_i  = r.compressed;
        branch_predict_i = r.pred;
        csr_commit_i     = r.commit;
        flush_i          = r.flush;
    endtask

    // ------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------
    initial begin
        row_t cur;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        fu_data_i        = '0;
        issue_i          = ISSUE_NONE;
        pc_i             = '0;
        is_compressed_i  = 1'b0;
        branch_predict_i = '0;
        csr_commit_i     = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (RST_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        rst_ni = 1'b1;

        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            cur = rows[row_idx];
            @(posedge clk_i);
            #DRIVE_DLY;
            apply_row(cur);
            #SAMPLE_DLY;
            check_wb(flu_wb_o, cur.exp_wb);
            check_resolve(resolved_branch_o, cur.exp_res, cur.chk_target);
            check_csr(flu_ready_o, csr_addr_o, cur.exp_ready, cur.exp_addr);
        end

        @(posedge clk_i);
        passed = 1'b1;
        $display("All checks passed");
        $finish;
    end

    // Watchdog, sized from the table once it exists
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (rows.size() + RST_CYCLES + 20) * CLK_PERIOD;
        #(limit_ns);
        report_failure($sformatf("Timeout: the table was not finished after %0d ns", limit_ns));
    end

    // Catches a stop from a failing assertion
    final begin
        if (!passed && !fail_reported) begin
            $display("The run stopped before every table row was checked");
            $display("Checks failed");
        end
    end

endmodule

`default_nettype wire

//--- flist.f
design/ex_pkg.sv
design/alu.sv
design/branch_unit.sv
design/csr_buffer.sv
design/mult.sv
design/ex_stage.sv
testbench/ex_stage_sva.sv
testbench/tb_ex_stage.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
